// ==== verilog.f ====
source/stream_pkg.sv
source/sync_fifo.sv
source/addr_gen.sv
source/load_streamer.sv
source/operand_join.sv
source/dual_source_top.sv
sim/tb_memory.sv
sim/dual_source_assertions.sv
sim/tb_dual_source.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_dual_source
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  := === PASS ===

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# fails unless the pass line shows up in the simulation output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/tb_dual_source.sv ====
// testbench for dual_source_top with two random-timing scratchpad models
// all patterns in one run must give both streams the same beat count
`timescale 1ns/1ps

module tb_dual_source;
  import stream_pkg::*;

  localparam int          OFS_DEPTH   = 8;
  localparam int          CNT_W       = 16;
  localparam int          CLK_PERIOD  = 8;      // ns
  localparam logic [31:0] SEED        = 32'd33840;
  localparam int          RUN_TIMEOUT = 20000;  // cycles for a whole run
  localparam int          ACK_TIMEOUT = 20;     // cycles for ack to drop

  logic          clk;
  logic          rst_n;
  logic          clear;
  run_cfg_t      cfg;
  logic          start_req;
  logic          start_ack;
  mem_req_t      mem_a_req;
  mem_req_t      mem_b_req;
  mem_rsp_t      mem_a_rsp;
  mem_rsp_t      mem_b_rsp;
  operand_pair_t pair;
  logic          pair_valid;
  logic          pair_ready = 1'b0;
  logic          rand_mode;
  logic [31:0]   rand_a     = '0;
  logic [31:0]   rand_b     = '0;
  logic [31:0]   lcg_state  = SEED;
  operand_pair_t got_q[$];  // pairs in transfer order
  int            err_cnt;
  int            test_pass;
  int            test_fail;
  logic          timed_out;

  dual_source_top #(.OFS_DEPTH(OFS_DEPTH), .CNT_W(CNT_W)) dual_source_top_i (
    .clk_i(clk), .rst_ni(rst_n), .clear_i(clear), .cfg_i(cfg),
    .start_req_i(start_req), .start_ack_o(start_ack),
    .mem_a_req_o(mem_a_req), .mem_a_rsp_i(mem_a_rsp),
    .mem_b_req_o(mem_b_req), .mem_b_rsp_i(mem_b_rsp),
    .pair_o(pair), .pair_valid_o(pair_valid), .pair_ready_i(pair_ready));

  tb_memory #(.MAX_LAT(OFS_DEPTH)) mem_a (.clk_i(clk), .rst_ni(rst_n), .rand_mode_i(rand_mode),
    .rand_i(rand_a), .req_i(mem_a_req), .rsp_o(mem_a_rsp));
  tb_memory #(.MAX_LAT(OFS_DEPTH)) mem_b (.clk_i(clk), .rst_ni(rst_n), .rand_mode_i(rand_mode),
    .rand_i(rand_b), .req_i(mem_b_req), .rsp_o(mem_b_rsp));

  bind dual_source_top dual_source_assertions u_assert (
    .*, .a_state_i(u_src_a.cs), .b_state_i(u_src_b.cs));

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // fresh draws each cycle, upper bits only
  always @(posedge clk) begin
    lcg_state = lcg_next(lcg_state);
    rand_a <= lcg_state;
    lcg_state = lcg_next(lcg_state);
    rand_b <= lcg_state;
    lcg_state = lcg_next(lcg_state);
    pair_ready <= !rand_mode || (lcg_state[31:30] != 2'b00);
  end

  always @(negedge clk) begin
    if (rst_n && pair_valid && pair_ready) got_q.push_back(pair);  // transfers next edge
  end

  function automatic beat_t beat_at(input logic [31:0] x);
    beat_t       w;
    logic [31:0] v;
    for (int i = 0; i < 4; i++) begin
      v = (x + 32'(i)) * 32'd7 + 32'd3;
      w[8*i +: 8] = v[7:0];  // lowest address in the low byte
    end
    return w;
  endfunction

  function automatic void expected_beats(input pattern_cfg_t p, ref beat_t q[$]);
    logic [31:0] x;
    q.delete();
    for (int r = 0; r < int'(p.row_cnt); r++) begin
      for (int c = 0; c < int'(p.row_len); c++) begin
        x = p.base_addr + 32'(r) * p.row_stride + 32'(c) * 32'(p.beat_stride);
        q.push_back(beat_at(x));
      end
    end
  endfunction

  function automatic pattern_cfg_t pattern(input logic [31:0] base, input int len,
                                           input int rows, input int stride, input int rstride);
    pattern_cfg_t p;
    p.base_addr   = base;
    p.row_len     = 16'(len);
    p.row_cnt     = 16'(rows);
    p.beat_stride = 16'(stride);
    p.row_stride  = 32'(rstride);
    return p;
  endfunction

  task automatic wait_ack(input logic level, input int limit, input string name);
    int n;
    n = 0;
    while (start_ack !== level && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (start_ack !== level) begin
      $display("%s: timed out waiting for start_ack_o to go %0b", name, level);
      timed_out = 1'b1;
    end
  endtask

  task automatic report_test(input string name, input int errs);
    err_cnt += errs;
    if (errs == 0 && !timed_out) begin
      test_pass++;
      $display("test %-16s ok", name);
    end else begin
      test_fail++;
      $display("test %-16s failed, %0d errors", name, errs);
    end
  endtask

  task automatic run_test(input string name, input run_cfg_t c, input logic rnd);
    beat_t exp_a[$];
    beat_t exp_b[$];
    int    errs;
    if (timed_out) return;
    errs = 0;
    expected_beats(c.a, exp_a);
    expected_beats(c.b, exp_b);
    got_q.delete();
    @(posedge clk);
    cfg       <= c;
    rand_mode <= rnd;
    @(posedge clk);
    start_req <= 1'b1;
    @(negedge clk);
    wait_ack(1'b1, RUN_TIMEOUT, name);
    if (!timed_out) begin
      // ack must not come before the last pair
      assert (got_q.size() == exp_a.size()) else begin
        $display("ERR %s pair count exp %0d got %0d", name, exp_a.size(), got_q.size());
        errs++;
      end
      foreach (got_q[i]) begin
        if (i < exp_a.size()) begin
          assert (got_q[i].op_a == exp_a[i] && got_q[i].op_b == exp_b[i]) else begin
            $display("ERR %s pair %0d exp %h_%h got %h_%h", name, i, exp_a[i], exp_b[i],
                     got_q[i].op_a, got_q[i].op_b);
            errs++;
          end
        end
      end
      @(posedge clk);
      start_req <= 1'b0;
      @(negedge clk);
      wait_ack(1'b0, ACK_TIMEOUT, name);
    end
    report_test(name, errs);
  endtask

  task automatic clear_test();
    int errs;
    int n;
    if (timed_out) return;
    errs = 0;
    n = 0;
    got_q.delete();
    @(posedge clk);
    cfg       <= '{a: pattern(32'h3000, 40, 4, 4, 256), b: pattern(32'h5001, 40, 4, 4, 256)};
    rand_mode <= 1'b1;
    @(posedge clk);
    start_req <= 1'b1;
    while (got_q.size() < 10 && n < RUN_TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (got_q.size() < 10) begin
      $display("clear_abort: timed out before the run got going");
      timed_out = 1'b1;
    end
    @(posedge clk);
    clear <= 1'b1;  // abort mid-run
    @(posedge clk);
    clear     <= 1'b0;
    start_req <= 1'b0;
    @(negedge clk);
    // streamers back in idle, so no pair and no load request
    assert (!pair_valid && !start_ack && !mem_a_req.req && !mem_b_req.req) else begin
      $display("clear_abort: pair stream or memory port still active after clear_i");
      errs++;
    end
    report_test("clear_abort", errs);
  endtask

  initial begin
    rst_n     = 1'b0;
    clear     = 1'b0;
    start_req = 1'b0;
    cfg       = '0;
    rand_mode = 1'b0;
    err_cnt   = 0;
    test_pass = 0;
    test_fail = 0;
    timed_out = 1'b0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    run_test("aligned_row",
             '{a: pattern(32'h0100, 16, 1, 4, 0), b: pattern(32'h0400, 16, 1, 4, 0)}, 1'b0);
    run_test("misalign_a1_b3",
             '{a: pattern(32'h0201, 12, 1, 4, 0), b: pattern(32'h0603, 12, 1, 4, 0)}, 1'b0);
    run_test("misalign_a2_b2",
             '{a: pattern(32'h0302, 12, 1, 4, 0), b: pattern(32'h0702, 12, 1, 4, 0)}, 1'b0);
    run_test("misalign_a3_b1",
             '{a: pattern(32'h0083, 12, 1, 5, 0), b: pattern(32'h00a1, 12, 1, 3, 0)}, 1'b0);
    run_test("two_dim",
             '{a: pattern(32'h1000, 5, 4, 4, 'h40), b: pattern(32'h2002, 5, 4, 8, 'h31)}, 1'b0);
    run_test("random_timing",
             '{a: pattern(32'h0123, 7, 6, 3, 'h50), b: pattern(32'h0456, 7, 6, 6, 'h29)}, 1'b1);
    clear_test();
    run_test("after_clear",
             '{a: pattern(32'h0811, 9, 3, 4, 'h30), b: pattern(32'h0c0e, 9, 3, 7, 'h45)}, 1'b1);
    $display("tests passed %0d failed %0d, value errors %0d, assertion failures %0d",
             test_pass, test_fail, err_cnt, dual_source_top_i.u_assert.fail_cnt);
    if (test_fail == 0 && err_cnt == 0 && !timed_out &&
        dual_source_top_i.u_assert.fail_cnt == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== sim/dual_source_assertions.sv ====
// protocol checks for dual_source_top, all disabled in reset and most during clear_i
// fail_cnt holds the number of failed checks
`timescale 1ns/1ps

module dual_source_assertions (
  input logic                          clk_i,
  input logic                          rst_ni,
  input logic                          clear_i,
  input logic                          start_req_i,
  input logic                          start_ack_o,
  input stream_pkg::mem_req_t          mem_a_req_o,
  input stream_pkg::mem_rsp_t          mem_a_rsp_i,
  input stream_pkg::mem_req_t          mem_b_req_o,
  input stream_pkg::mem_rsp_t          mem_b_rsp_i,
  input stream_pkg::operand_pair_t     pair_o,
  input logic                          pair_valid_o,
  input logic                          pair_ready_i,
  input stream_pkg::streamer_state_t   a_state_i,
  input stream_pkg::streamer_state_t   b_state_i
);
  import stream_pkg::*;

  int unsigned fail_cnt = 0;
  int unsigned out_a_q;  // loads granted, response not yet seen
  int unsigned out_b_q;

  // memory side is not cleared, so neither are these
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_a_q <= 0;
      out_b_q <= 0;
    end else begin
      out_a_q <= out_a_q + 32'(mem_a_req_o.req && mem_a_rsp_i.gnt) - 32'(mem_a_rsp_i.r_valid);
      out_b_q <= out_b_q + 32'(mem_b_req_o.req && mem_b_rsp_i.gnt) - 32'(mem_b_rsp_i.r_valid);
    end
  end

  pair_stable: assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    pair_valid_o && !pair_ready_i |=> pair_valid_o && $stable(pair_o))
    else begin $error("pair dropped or changed under back-pressure"); fail_cnt++; end

  a_addr_held: assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    mem_a_req_o.req && !mem_a_rsp_i.gnt |=> mem_a_req_o.req && $stable(mem_a_req_o.addr))
    else begin $error("port a request withdrawn before grant"); fail_cnt++; end

  b_addr_held: assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    mem_b_req_o.req && !mem_b_rsp_i.gnt |=> mem_b_req_o.req && $stable(mem_b_req_o.addr))
    else begin $error("port b request withdrawn before grant"); fail_cnt++; end

  // loads only between start_req_i rising and start_ack_o rising
  a_req_active: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_a_req_o.req |-> a_state_i != st_idle && start_req_i && !start_ack_o)
    else begin $error("port a request outside a run"); fail_cnt++; end

  b_req_active: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_b_req_o.req |-> b_state_i != st_idle && start_req_i && !start_ack_o)
    else begin $error("port b request outside a run"); fail_cnt++; end

  a_rsp_owed: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_a_rsp_i.r_valid |-> out_a_q != 0)
    else begin $error("port a response with no load outstanding"); fail_cnt++; end

  b_rsp_owed: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_b_rsp_i.r_valid |-> out_b_q != 0)
    else begin $error("port b response with no load outstanding"); fail_cnt++; end

  ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    $rose(start_ack_o) |-> start_req_i)
    else begin $error("start_ack_o rose without start_req_i"); fail_cnt++; end

  ack_held: assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    start_ack_o && start_req_i |=> start_ack_o)
    else begin $error("start_ack_o fell while start_req_i high"); fail_cnt++; end

  ack_release: assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    start_ack_o && !start_req_i |=> !start_ack_o)
    else begin $error("start_ack_o stuck after start_req_i fell"); fail_cnt++; end

endmodule

// ==== sim/tb_memory.sv ====
// scratchpad read port model; byte at x is low 8 bits of x*7+3, responses in grant order
// rand_mode_i low gives a grant every cycle and latency 1, high draws both from rand_i
`timescale 1ns/1ps

module tb_memory #(
  parameter int MAX_LAT = 8
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 rand_mode_i,
  input  logic [31:0]          rand_i,       // new word every cycle
  input  stream_pkg::mem_req_t req_i,
  output stream_pkg::mem_rsp_t rsp_o
);
  import stream_pkg::*;

  logic        gnt;
  logic        r_valid_q;
  mem_word_t   r_data_q;
  int unsigned cyc_q;
  int unsigned last_due_q;  // cycle of the youngest pending response
  int unsigned due_q[$];    // cycle each pending response shows up
  logic [31:0] addr_q[$];

  function automatic logic [7:0] mem_byte(input logic [31:0] x);
    logic [31:0] v;
    v = x * 32'd7 + 32'd3;
    return v[7:0];
  endfunction

  function automatic mem_word_t read_word(input logic [31:0] a);
    mem_word_t w;
    for (int i = 0; i < 8; i++) begin
      w[8*i +: 8] = mem_byte(a + 32'(i));  // byte 0 in the low lane
    end
    return w;
  endfunction

  assign gnt   = !rand_mode_i || (rand_i[31:30] != 2'b00);  // about 3 in 4 when random
  assign rsp_o = '{gnt: gnt, r_valid: r_valid_q, r_data: r_data_q};

  always @(posedge clk_i or negedge rst_ni) begin
    int unsigned lat;
    int unsigned due;
    if (!rst_ni) begin
      due_q.delete();
      addr_q.delete();
      cyc_q      <= 0;
      last_due_q <= 0;
      r_valid_q  <= 1'b0;
      r_data_q   <= '0;
    end else begin
      if (req_i.req && gnt) begin
        lat = rand_mode_i ? 1 + (rand_i[29:22] % MAX_LAT) : 1;
        due = cyc_q + lat;
        if (due <= last_due_q) due = last_due_q + 1;  // never overtake an older load
        due_q.push_back(due);
        addr_q.push_back(req_i.addr);
        last_due_q <= due;
      end
      if (due_q.size() != 0 && due_q[0] == cyc_q + 1) begin
        r_valid_q <= 1'b1;
        r_data_q  <= read_word(addr_q.pop_front());
        due_q.delete(0);
      end else begin
        r_valid_q <= 1'b0;
      end
      cyc_q <= cyc_q + 1;
    end
  end

endmodule

// ==== source/dual_source_top.sv ====
// two load streamers into one operand-pair stream, run started by four-phase req/ack
// cfg_i must stay stable from start_req_i rising until start_ack_o falls
`timescale 1ns/1ps

module dual_source_top #(
  parameter int OFS_DEPTH = 8,
  parameter int CNT_W     = 16
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      clear_i,
  input  stream_pkg::run_cfg_t      cfg_i,
  input  logic                      start_req_i,
  output logic                      start_ack_o,
  output stream_pkg::mem_req_t      mem_a_req_o,
  input  stream_pkg::mem_rsp_t      mem_a_rsp_i,
  output stream_pkg::mem_req_t      mem_b_req_o,
  input  stream_pkg::mem_rsp_t      mem_b_rsp_i,
  output stream_pkg::operand_pair_t pair_o,
  output logic                      pair_valid_o,
  input  logic                      pair_ready_i
);
  import stream_pkg::*;

  beat_t a_beat, b_beat;
  logic  a_valid, a_ready, a_done;
  logic  b_valid, b_ready, b_done;
  logic  start_req_q;  // for edge detect
  logic  run_q;        // run in progress
  logic  a_done_q, b_done_q;
  logic  start;

  assign start = start_req_i & ~start_req_q & ~run_q & ~start_ack_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      start_req_q <= 1'b0;
      run_q       <= 1'b0;
      a_done_q    <= 1'b0;
      b_done_q    <= 1'b0;
      start_ack_o <= 1'b0;
    end else if (clear_i) begin
      start_req_q <= start_req_i;  // a held req does not restart after abort
      run_q       <= 1'b0;
      a_done_q    <= 1'b0;
      b_done_q    <= 1'b0;
      start_ack_o <= 1'b0;
    end else begin
      start_req_q <= start_req_i;
      if (start) begin
        run_q    <= 1'b1;
        a_done_q <= 1'b0;
        b_done_q <= 1'b0;
      end else if (run_q) begin
        if (a_done) a_done_q <= 1'b1;
        if (b_done) b_done_q <= 1'b1;
        if ((a_done_q | a_done) && (b_done_q | b_done)) begin
          run_q       <= 1'b0;
          start_ack_o <= 1'b1;  // both streamers back in idle
        end
      end
      if (start_ack_o && !start_req_i) start_ack_o <= 1'b0;  // one cycle after req drops
    end
  end

  load_streamer #(
    .OFS_DEPTH ( OFS_DEPTH ),
    .CNT_W     ( CNT_W     )
  ) u_src_a (
    .clk_i        ( clk_i       ),
    .rst_ni       ( rst_ni      ),
    .clear_i      ( clear_i     ),
    .start_i      ( start       ),
    .cfg_i        ( cfg_i.a     ),
    .mem_rsp_i    ( mem_a_rsp_i ),
    .beat_ready_i ( a_ready     ),
    .mem_req_o    ( mem_a_req_o ),
    .beat_o       ( a_beat      ),
    .beat_valid_o ( a_valid     ),
    .done_o       ( a_done      )
  );

  load_streamer #(
    .OFS_DEPTH ( OFS_DEPTH ),
    .CNT_W     ( CNT_W     )
  ) u_src_b (
    .clk_i        ( clk_i       ),
    .rst_ni       ( rst_ni      ),
    .clear_i      ( clear_i     ),
    .start_i      ( start       ),
    .cfg_i        ( cfg_i.b     ),
    .mem_rsp_i    ( mem_b_rsp_i ),
    .beat_ready_i ( b_ready     ),
    .mem_req_o    ( mem_b_req_o ),
    .beat_o       ( b_beat      ),
    .beat_valid_o ( b_valid     ),
    .done_o       ( b_done      )
  );

  operand_join u_join (
    .a_i          ( a_beat       ),
    .a_valid_i    ( a_valid      ),
    .a_ready_o    ( a_ready      ),
    .b_i          ( b_beat       ),
    .b_valid_i    ( b_valid      ),
    .b_ready_o    ( b_ready      ),
    .pair_o       ( pair_o       ),
    .pair_valid_o ( pair_valid_o ),
    .pair_ready_i ( pair_ready_i )
  );

endmodule

// ==== source/operand_join.sv ====
// pairs beats of two streams one for one, purely combinational
`timescale 1ns/1ps

module operand_join (
  input  stream_pkg::beat_t         a_i,
  input  logic                      a_valid_i,
  output logic                      a_ready_o,
  input  stream_pkg::beat_t         b_i,
  input  logic                      b_valid_i,
  output logic                      b_ready_o,
  output stream_pkg::operand_pair_t pair_o,
  output logic                      pair_valid_o,
  input  logic                      pair_ready_i
);
  import stream_pkg::*;

  operand_pair_t pair;

  assign pair.op_a = a_i;
  assign pair.op_b = b_i;
  assign pair_o    = pair;

  // both sides must be present, so neither stream runs ahead
  assign pair_valid_o = a_valid_i & b_valid_i;
  assign a_ready_o    = pair_ready_i & b_valid_i;  // take a only with a partner
  assign b_ready_o    = pair_ready_i & a_valid_i;

endmodule

// ==== source/load_streamer.sv ====
// source streamer: strided loads over req/gnt, 64-bit reads realigned to 32-bit beats
// response latency must stay within OFS_DEPTH cycles of the grant
`timescale 1ns/1ps

module load_streamer #(
  parameter int OFS_DEPTH = 8,
  parameter int CNT_W     = 16
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     clear_i,
  input  logic                     start_i,
  input  stream_pkg::pattern_cfg_t cfg_i,
  input  stream_pkg::mem_rsp_t     mem_rsp_i,
  input  logic                     beat_ready_i,
  output stream_pkg::mem_req_t     mem_req_o,
  output stream_pkg::beat_t        beat_o,
  output logic                     beat_valid_o,
  output logic                     done_o
);
  import stream_pkg::*;

  localparam int CRD_W = $clog2(OFS_DEPTH) + 1;
  localparam int OUT_W = CRD_W + 1;  // room for an aborted run's tail

  streamer_state_t cs, ns;
  logic [CRD_W-1:0] credit_q;   // grant to beat transfer
  logic [OUT_W-1:0] out_q;      // grant to response
  logic [OUT_W-1:0] out_d;
  logic [OUT_W-1:0] drop_q;     // responses left over from a cleared run
  logic [31:0]      gen_addr;
  logic             gen_last;
  logic             gen_load;
  logic             grant;
  logic             rsp_keep;
  logic             beat_xfer;
  logic             data_push;
  logic             data_empty;
  logic             ofs_empty;
  logic [1:0]       ofs_head;
  mem_word_t        data_head;
  mem_word_t        word_sel;

  assign gen_load       = start_i && (cs == st_idle);
  assign mem_req_o.req  = (cs == st_working) && (credit_q != CRD_W'(OFS_DEPTH));
  assign mem_req_o.addr = {gen_addr[31:2], 2'b00};  // word aligned, held until gnt
  assign grant          = mem_req_o.req & mem_rsp_i.gnt;

  addr_gen #(
    .CNT_W ( CNT_W )
  ) u_addr_gen (
    .clk_i     ( clk_i    ),
    .rst_ni    ( rst_ni   ),
    .clear_i   ( clear_i  ),
    .load_i    ( gen_load ),
    .cfg_i     ( cfg_i    ),
    .advance_i ( grant    ),
    .addr_o    ( gen_addr ),
    .last_o    ( gen_last )
  );

  // byte offset of every granted load, consumed with its beat
  sync_fifo #(
    .payload_t ( logic [1:0] ),
    .DEPTH     ( OFS_DEPTH   )
  ) u_ofs_fifo (
    .clk_i   ( clk_i          ),
    .rst_ni  ( rst_ni         ),
    .clear_i ( clear_i        ),
    .push_i  ( grant          ),
    .data_i  ( gen_addr[1:0]  ),
    .pop_i   ( beat_xfer      ),
    .data_o  ( ofs_head       ),
    .empty_o ( ofs_empty      ),
    .full_o  (                )
  );

  // response words not taken straight through
  sync_fifo #(
    .payload_t ( mem_word_t ),
    .DEPTH     ( OFS_DEPTH  )
  ) u_data_fifo (
    .clk_i   ( clk_i                   ),
    .rst_ni  ( rst_ni                  ),
    .clear_i ( clear_i                 ),
    .push_i  ( data_push               ),
    .data_i  ( mem_rsp_i.r_data        ),
    .pop_i   ( beat_xfer & ~data_empty ),
    .data_o  ( data_head               ),
    .empty_o ( data_empty              ),
    .full_o  (                         )
  );

  assign rsp_keep     = mem_rsp_i.r_valid && (drop_q == '0);  // stale ones dropped
  assign beat_valid_o = (rsp_keep | ~data_empty) & ~ofs_empty;
  assign beat_xfer    = beat_valid_o & beat_ready_i;
  assign data_push    = rsp_keep & ~(data_empty & beat_xfer);  // bypass taken directly
  assign word_sel     = data_empty ? mem_rsp_i.r_data : data_head;
  assign beat_o       = beat_t'(word_sel >> {ofs_head, 3'b000});  // little endian shift

  // credits bound both FIFOs
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_q <= '0;
    end else if (clear_i) begin
      credit_q <= '0;
    end else begin
      case ({grant, beat_xfer})
        2'b10:   credit_q <= credit_q + 1'b1;
        2'b01:   credit_q <= credit_q - 1'b1;
        default: ;
      endcase
    end
  end

  // in-flight count survives clear so late responses can be discarded
  assign out_d = out_q + OUT_W'(grant) - OUT_W'(mem_rsp_i.r_valid);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_q  <= '0;
      drop_q <= '0;
    end else begin
      out_q <= out_d;
      if (clear_i) drop_q <= out_d;  // everything in flight is stale
      else if (mem_rsp_i.r_valid && drop_q != '0) drop_q <= drop_q - 1'b1;
    end
  end

  always_comb begin
    ns     = cs;
    done_o = 1'b0;
    case (cs)
      st_idle:     if (start_i) ns = st_working;
      st_working:  if (grant && gen_last) ns = st_draining;  // final address accepted
      st_draining: begin
        if (credit_q == '0 && data_empty) begin
          ns     = st_idle;
          done_o = 1'b1;  // single cycle, last beat already gone
        end
      end
      default:     ns = st_idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni)      cs <= st_idle;
    else if (clear_i) cs <= st_idle;
    else              cs <= ns;
  end

endmodule

// ==== source/addr_gen.sv ====
// two-level strided byte address walk, unsigned strides, wraps at 2^32
// row_len and row_cnt are truncated to CNT_W bits
`timescale 1ns/1ps

module addr_gen #(
  parameter int CNT_W = 16
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     clear_i,
  input  logic                     load_i,
  input  stream_pkg::pattern_cfg_t cfg_i,
  input  logic                     advance_i,
  output logic [31:0]              addr_o,
  output logic                     last_o
);
  import stream_pkg::*;

  pattern_cfg_t     cfg_q;       // captured pattern
  logic [31:0]      addr_q;      // current address
  logic [31:0]      row_base_q;  // start of current row
  logic [CNT_W-1:0] beat_cnt_q;
  logic [CNT_W-1:0] row_cnt_q;
  logic             row_end;
  logic [31:0]      next_row;

  assign row_end  = (beat_cnt_q == CNT_W'(cfg_q.row_len - 16'd1));
  assign next_row = row_base_q + cfg_q.row_stride;
  assign addr_o   = addr_q;
  assign last_o   = row_end && (row_cnt_q == CNT_W'(cfg_q.row_cnt - 16'd1));

  always_ff @(posedge clk_i) begin
    if (load_i) cfg_q <= cfg_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q     <= '0;
      row_base_q <= '0;
      beat_cnt_q <= '0;
      row_cnt_q  <= '0;
    end else if (clear_i) begin
      beat_cnt_q <= '0;
      row_cnt_q  <= '0;
    end else if (load_i) begin
      addr_q     <= cfg_i.base_addr;  // first address valid next cycle
      row_base_q <= cfg_i.base_addr;
      beat_cnt_q <= '0;
      row_cnt_q  <= '0;
    end else if (advance_i) begin
      if (row_end) begin
        addr_q     <= next_row;  // jump to next row start
        row_base_q <= next_row;
        beat_cnt_q <= '0;
        row_cnt_q  <= row_cnt_q + 1'b1;
      end else begin
        addr_q     <= addr_q + {16'd0, cfg_q.beat_stride};
        beat_cnt_q <= beat_cnt_q + 1'b1;
      end
    end
  end

endmodule

// ==== source/sync_fifo.sv ====
// registered-output FIFO, no fall-through; DEPTH must be a power of two >= 2
// push on full or pop on empty is not guarded here
`timescale 1ns/1ps

module sync_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 8
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     clear_i,
  input  logic     push_i,
  input  payload_t data_i,
  input  logic     pop_i,
  output payload_t data_o,
  output logic     empty_o,
  output logic     full_o
);

  localparam int AW = $clog2(DEPTH);

  payload_t       mem_q [DEPTH];  // storage, no reset
  logic [AW-1:0]  wr_ptr_q;
  logic [AW-1:0]  rd_ptr_q;
  logic [AW:0]    count_q;        // one extra bit to tell full from empty

  assign data_o  = mem_q[rd_ptr_q];
  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == (AW+1)'(DEPTH));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) wr_ptr_q <= wr_ptr_q + 1'b1;  // wraps, power-of-two depth
      if (pop_i)  rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;  // both or neither, level unchanged
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) mem_q[wr_ptr_q] <= data_i;
  end

endmodule

// ==== source/stream_pkg.sv ====
// shared types for the dual-operand load path; memory words are 64 bits, beats 32
// all addresses are byte addresses, memory ports only see 4-byte aligned ones
package stream_pkg;

  typedef logic [31:0] beat_t;      // one streamer output beat
  typedef logic [63:0] mem_word_t;  // 8 bytes from an aligned address, byte 0 in [7:0]

  // one streamer's access pattern
  typedef struct packed {
    logic [31:0] base_addr;    // any byte alignment
    logic [15:0] row_len;      // beats per row, >= 1
    logic [15:0] row_cnt;      // rows, >= 1
    logic [15:0] beat_stride;  // byte step inside a row
    logic [31:0] row_stride;   // byte step between row starts
  } pattern_cfg_t;

  typedef struct packed {
    pattern_cfg_t a;
    pattern_cfg_t b;
  } run_cfg_t;

  // scratchpad read port, initiator side
  typedef struct packed {
    logic        req;
    logic [31:0] addr;  // low two bits always zero
  } mem_req_t;

  // scratchpad read port, target side
  typedef struct packed {
    logic      gnt;
    logic      r_valid;  // in grant order, never stalled
    mem_word_t r_data;
  } mem_rsp_t;

  typedef struct packed {
    beat_t op_a;
    beat_t op_b;
  } operand_pair_t;

  typedef enum logic [1:0] {
    st_idle     = 2'd0,
    st_working  = 2'd1,  // issuing loads
    st_draining = 2'd2   // last load granted, waiting for beats to leave
  } streamer_state_t;

endpackage
